//--- logic/csr_pkg.sv
// CSR addresses, reset values, mstatus bit positions, operation codes and CSR bus types
package csr_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // rs1 index for register forms, immediate for the I forms
  typedef logic [4:0] zimm_t;

  // funct3 encoding of the Zicsr instructions
  typedef enum logic [2:0] {
    CSRRW  = 3'd1,
    CSRRS  = 3'd2,
    CSRRC  = 3'd3,
    CSRRWI = 3'd5,
    CSRRSI = 3'd6,
    CSRRCI = 3'd7
  } csr_op_t;

  // machine mode CSR addresses
  localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
  localparam csr_addr_t ADDR_MIE      = 12'h304;
  localparam csr_addr_t ADDR_MTVEC    = 12'h305;
  localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
  localparam csr_addr_t ADDR_MEPC     = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
  localparam csr_addr_t ADDR_MCYCLE   = 12'hB00;
  localparam csr_addr_t ADDR_MHARTID  = 12'hF14;

  localparam word_t MTVEC_RESET = 32'h0000_0100;
  localparam word_t HART_ID     = 32'h0000_0000;

  // mstatus interrupt enable bits
  localparam int unsigned MSTATUS_MIE  = 3;
  localparam int unsigned MSTATUS_MPIE = 7;

  // request from the core, 53 bits
  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    csr_op_t   op;
    zimm_t     zimm;
    word_t     rs1_data;
  } csr_req_t;

  // old value of the CSR, one cycle after the request
  typedef struct packed {
    logic  valid;
    word_t rdata;
    logic  illegal;
  } csr_resp_t;

  typedef struct packed {
    logic  valid;
    word_t cause;
    word_t pc;
  } trap_req_t;

  // side-effect write, wins over a software write
  typedef struct packed {
    logic  enable;
    word_t data;
  } csr_ext_wr_t;

  typedef struct packed {
    csr_ext_wr_t mstatus;
    csr_ext_wr_t mepc;
    csr_ext_wr_t mcause;
  } trap_upd_t;

  // one-hot register select out of the address decoder
  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mcycle;
    logic mhartid;
  } csr_sel_t;

endpackage

//--- logic/csr_reg.sv
// single CSR with Zicsr read-modify-write logic and a priority external write port
module csr_reg #(
  parameter int unsigned      Width      = 32,
  parameter logic [Width-1:0] ResetValue = '0,
  parameter bit               Writable   = 1'b1
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  csr_pkg::csr_op_t     op,
  input  csr_pkg::zimm_t       zimm,
  input  csr_pkg::word_t       rs1_data,
  input  csr_pkg::csr_ext_wr_t ext,
  output csr_pkg::word_t       next_value,
  output csr_pkg::word_t       value
);
  import csr_pkg::*;

  logic [Width-1:0] data;
  logic [Width-1:0] source;
  logic [Width-1:0] result;

  // I forms take zimm zero-extended
  always_comb begin
    if (op == CSRRWI || op == CSRRSI || op == CSRRCI) begin
      source = Width'(zimm);
    end else begin
      source = Width'(rs1_data);
    end
  end

  // set and clear only write when zimm (or the rs1 index) is nonzero
  always_comb begin
    result = data;
    if (enable) begin
      case (op)
        CSRRW, CSRRWI: result = source;
        CSRRS, CSRRSI: begin
          if (zimm != '0) begin
            result = data | source;
          end
        end
        CSRRC, CSRRCI: begin
          if (zimm != '0) begin
            result = data & ~source;
          end
        end
        default: result = data;
      endcase
    end
  end

  if (Writable) begin : g_store
    always_ff @(posedge clk) begin
      if (reset) begin
        data <= ResetValue;
      end else if (ext.enable) begin
        data <= ext.data[Width-1:0];
      end else begin
        data <= result;
      end
    end
    assign next_value = word_t'(result);
  end else begin : g_const
    // read-only, value fixed at elaboration
    assign data       = ResetValue;
    assign next_value = word_t'(data);
  end

  assign value = word_t'(data);

endmodule

//--- logic/csr_counter.sv
// free-running mcycle counter with software write access
module csr_counter (
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,
  input  csr_pkg::csr_op_t op,
  input  csr_pkg::zimm_t   zimm,
  input  csr_pkg::word_t   rs1_data,
  output csr_pkg::word_t   value
);
  import csr_pkg::*;

  word_t       next_value;
  csr_ext_wr_t step;

  // ext port is always on, so the stored value is the
  // software result plus one, every cycle
  assign step = '{enable: 1'b1, data: next_value + 32'd1};

  csr_reg #(
    .Width     (32),
    .ResetValue('0),
    .Writable  (1'b1)
  ) i_csr_reg (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .op        (op),
    .zimm      (zimm),
    .rs1_data  (rs1_data),
    .ext       (step),
    .next_value(next_value),
    .value     (value)
  );

endmodule

//--- logic/csr_file.sv
// CSR address decode, register instances, read mux and registered response
module csr_file (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_req_t  req,
  input  csr_pkg::trap_upd_t upd,
  output csr_pkg::csr_resp_t resp,
  output csr_pkg::word_t     mstatus,
  output csr_pkg::word_t     mtvec,
  output csr_pkg::word_t     mepc
);
  import csr_pkg::*;

  csr_sel_t    sel;
  csr_sel_t    wr_en;
  logic        writes;
  logic        illegal;
  word_t       mie;
  word_t       mscratch;
  word_t       mcause;
  word_t       mcycle;
  word_t       mhartid;
  word_t       rdata;

  // the only place an address is compared
  always_comb begin
    sel = '0;
    case (req.addr)
      ADDR_MSTATUS:  sel.mstatus  = 1'b1;
      ADDR_MIE:      sel.mie      = 1'b1;
      ADDR_MTVEC:    sel.mtvec    = 1'b1;
      ADDR_MSCRATCH: sel.mscratch = 1'b1;
      ADDR_MEPC:     sel.mepc     = 1'b1;
      ADDR_MCAUSE:   sel.mcause   = 1'b1;
      ADDR_MCYCLE:   sel.mcycle   = 1'b1;
      ADDR_MHARTID:  sel.mhartid  = 1'b1;
      default:       sel = '0;
    endcase
  end

  // set or clear with zimm zero is a pure read
  assign writes  = (req.op == CSRRW) || (req.op == CSRRWI) || (req.zimm != '0);
  assign illegal = (sel == '0) || (sel.mhartid && writes);
  assign wr_en   = (req.valid && !illegal) ? sel : '0;

  csr_reg #(.ResetValue('0)) i_mstatus (
    .clk(clk), .reset(reset), .enable(wr_en.mstatus),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext(upd.mstatus), .next_value(), .value(mstatus)
  );

  csr_reg #(.ResetValue('0)) i_mie (
    .clk(clk), .reset(reset), .enable(wr_en.mie),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext('0), .next_value(), .value(mie)
  );

  csr_reg #(.ResetValue(MTVEC_RESET)) i_mtvec (
    .clk(clk), .reset(reset), .enable(wr_en.mtvec),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext('0), .next_value(), .value(mtvec)
  );

  csr_reg #(.ResetValue('0)) i_mscratch (
    .clk(clk), .reset(reset), .enable(wr_en.mscratch),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext('0), .next_value(), .value(mscratch)
  );

  csr_reg #(.ResetValue('0)) i_mepc (
    .clk(clk), .reset(reset), .enable(wr_en.mepc),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext(upd.mepc), .next_value(), .value(mepc)
  );

  csr_reg #(.ResetValue('0)) i_mcause (
    .clk(clk), .reset(reset), .enable(wr_en.mcause),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext(upd.mcause), .next_value(), .value(mcause)
  );

  csr_counter i_mcycle (
    .clk(clk), .reset(reset), .enable(wr_en.mcycle),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .value(mcycle)
  );

  // hart id is constant, writes are caught as illegal above
  csr_reg #(.ResetValue(HART_ID), .Writable(1'b0)) i_mhartid (
    .clk(clk), .reset(reset), .enable(wr_en.mhartid),
    .op(req.op), .zimm(req.zimm), .rs1_data(req.rs1_data),
    .ext('0), .next_value(), .value(mhartid)
  );

  // old value of the selected register, zero when illegal
  always_comb begin
    rdata = '0;
    if (!illegal) begin
      case (1'b1)
        sel.mstatus:  rdata = mstatus;
        sel.mie:      rdata = mie;
        sel.mtvec:    rdata = mtvec;
        sel.mscratch: rdata = mscratch;
        sel.mepc:     rdata = mepc;
        sel.mcause:   rdata = mcause;
        sel.mcycle:   rdata = mcycle;
        sel.mhartid:  rdata = mhartid;
        default:      rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    resp.rdata   <= rdata;
    resp.illegal <= req.valid && illegal;
    if (reset) begin
      resp.valid <= 1'b0;
    end else begin
      resp.valid <= req.valid;
    end
  end

endmodule

//--- logic/csr_trap_ctrl.sv
// trap entry and mret updates of mstatus, mepc, mcause and the fetch redirect
module csr_trap_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::trap_req_t trap,
  input  logic               mret,
  input  csr_pkg::word_t     mstatus,
  input  csr_pkg::word_t     mtvec,
  input  csr_pkg::word_t     mepc,
  output csr_pkg::trap_upd_t upd,
  output logic               redirect_valid,
  output csr_pkg::word_t     redirect_pc
);
  import csr_pkg::*;

  word_t mstatus_next;
  word_t target;

  // trap wins if both arrive together
  always_comb begin
    mstatus_next = mstatus;
    if (trap.valid) begin
      // stack the interrupt enable and disable
      mstatus_next[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
      mstatus_next[MSTATUS_MIE]  = 1'b0;
    end else if (mret) begin
      // restore the enable, MPIE set afterwards
      mstatus_next[MSTATUS_MIE]  = mstatus[MSTATUS_MPIE];
      mstatus_next[MSTATUS_MPIE] = 1'b1;
    end
  end

  assign upd.mstatus = '{enable: trap.valid || mret, data: mstatus_next};
  assign upd.mepc    = '{enable: trap.valid, data: trap.pc};
  assign upd.mcause  = '{enable: trap.valid, data: trap.cause};

  // direct mode only, base is word aligned
  assign target = trap.valid ? {mtvec[31:2], 2'b00} : mepc;

  always_ff @(posedge clk) begin
    redirect_pc <= target;
    if (reset) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= trap.valid || mret;
    end
  end

endmodule

//--- logic/csr_unit.sv
// machine mode CSR unit top, register file plus trap and mret control
module csr_unit (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_req_t  req,
  input  csr_pkg::trap_req_t trap,
  input  logic               mret,
  output csr_pkg::csr_resp_t resp,
  output logic               redirect_valid,
  output csr_pkg::word_t     redirect_pc
);
  import csr_pkg::*;

  trap_upd_t upd;
  word_t     mstatus;
  word_t     mtvec;
  word_t     mepc;

  csr_file i_csr_file (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .upd    (upd),
    .resp   (resp),
    .mstatus(mstatus),
    .mtvec  (mtvec),
    .mepc   (mepc)
  );

  // reads current state, writes back through the ext ports
  csr_trap_ctrl i_csr_trap_ctrl (
    .clk           (clk),
    .reset         (reset),
    .trap          (trap),
    .mret          (mret),
    .mstatus       (mstatus),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .upd           (upd),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc)
  );

endmodule

//--- verif/csr_unit_asserts.sv
// concurrent assertions on the CSR response and fetch redirect, bound to csr_unit
module csr_unit_asserts (
  input logic               clk,
  input logic               reset,
  input csr_pkg::csr_req_t  req,
  input csr_pkg::trap_req_t trap,
  input logic               mret,
  input csr_pkg::csr_resp_t resp,
  input logic               redirect_valid
);
  import csr_pkg::*;

  // response exactly one cycle after each request
  resp_after_req: assert property (@(posedge clk) disable iff (reset)
    req.valid |=> resp.valid)
    else $error("request without a response in the next cycle");

  no_resp_without_req: assert property (@(posedge clk) disable iff (reset)
    !req.valid |=> !resp.valid)
    else $error("response without a request in the previous cycle");

  redirect_after_event: assert property (@(posedge clk) disable iff (reset)
    (trap.valid || mret) |=> redirect_valid)
    else $error("trap or mret without a redirect");

  // single pulse per event
  redirect_only_after_event: assert property (@(posedge clk) disable iff (reset)
    !(trap.valid || mret) |=> !redirect_valid)
    else $error("redirect without a trap or mret");

  trap_mret_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(trap.valid && mret))
    else $error("trap and mret in the same cycle");

endmodule

bind csr_unit csr_unit_asserts i_csr_unit_asserts (
  .clk           (clk),
  .reset         (reset),
  .req           (req),
  .trap          (trap),
  .mret          (mret),
  .resp          (resp),
  .redirect_valid(redirect_valid)
);

//--- verif/csr_unit_tb.sv
// CSR unit testbench with clock, reset, stimulus, reference model and response checks
module csr_unit_tb;
  import csr_pkg::*;

  // slots of the model array
  localparam int IDX_MSTATUS  = 0;
  localparam int IDX_MIE      = 1;
  localparam int IDX_MTVEC    = 2;
  localparam int IDX_MSCRATCH = 3;
  localparam int IDX_MEPC     = 4;
  localparam int IDX_MCAUSE   = 5;
  localparam int IDX_MCYCLE   = 6;
  localparam int IDX_MHARTID  = 7;
  localparam int RANDOM_OPS   = 200;
  // reset, then tests 1 to 6, then margin
  localparam int TIMEOUT_CYCLES = 4 + 12 + (RANDOM_OPS + 8) + 44 + 30 + 16 + 18 + 100;

  typedef struct packed {
    word_t rdata;
    word_t next;
    logic  illegal;
  } ref_result_t;

  logic        clk;
  logic        reset;
  csr_req_t    req;
  trap_req_t   trap;
  logic        mret;
  csr_resp_t   resp;
  logic        redirect_valid;
  word_t       redirect_pc;
  word_t       model [8];
  csr_addr_t   all_regs [8];
  ref_result_t exp_resp;
  logic        exp_resp_valid;
  logic        exp_redirect_valid;
  word_t       exp_redirect_pc;
  int          checks;
  int          errors;
  int          cycle_count;
  integer      seed;

  csr_unit i_csr_unit (
    .clk           (clk),
    .reset         (reset),
    .req           (req),
    .trap          (trap),
    .mret          (mret),
    .resp          (resp),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc)
  );

  always #10 clk = ~clk;

  function automatic int reg_index(input csr_addr_t addr);
    case (addr)
      ADDR_MSTATUS:  return IDX_MSTATUS;
      ADDR_MIE:      return IDX_MIE;
      ADDR_MTVEC:    return IDX_MTVEC;
      ADDR_MSCRATCH: return IDX_MSCRATCH;
      ADDR_MEPC:     return IDX_MEPC;
      ADDR_MCAUSE:   return IDX_MCAUSE;
      ADDR_MCYCLE:   return IDX_MCYCLE;
      ADDR_MHARTID:  return IDX_MHARTID;
      default:       return -1;
    endcase
  endfunction

  // old value, new value and illegal flag of one request against the model
  function automatic ref_result_t ref_csr(input csr_addr_t addr, input csr_op_t op,
                                          input zimm_t zimm, input word_t rs1_data);
    ref_result_t r;
    int          idx;
    logic        writes;
    word_t       src;
    idx    = reg_index(addr);
    writes = (op == CSRRW) || (op == CSRRWI) || (zimm != 5'd0);
    src    = (op == CSRRWI || op == CSRRSI || op == CSRRCI) ? {27'd0, zimm} : rs1_data;
    r      = '0;
    if (idx < 0 || (idx == IDX_MHARTID && writes)) begin
      r.illegal = 1'b1;
    end else begin
      r.rdata = model[idx];
      r.next  = model[idx];
      if (writes) begin
        case (op)
          CSRRW, CSRRWI: r.next = src;
          CSRRS, CSRRSI: r.next = model[idx] | src;
          default:       r.next = model[idx] & ~src;
        endcase
      end
    end
    return r;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic csr_op_t pick_op(input int k);
    case (k)
      0:       return CSRRW;
      1:       return CSRRS;
      2:       return CSRRC;
      3:       return CSRRWI;
      4:       return CSRRSI;
      default: return CSRRCI;
    endcase
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic issue(input csr_addr_t addr, input csr_op_t op, input zimm_t zimm,
                       input word_t data);
    @(posedge clk);
    req <= '{valid: 1'b1, addr: addr, op: op, zimm: zimm, rs1_data: data};
  endtask

  // set with x0 is a plain read
  task automatic read_csr(input csr_addr_t addr);
    issue(addr, CSRRS, 5'd0, word_t'($random(seed)));
  endtask

  task automatic read_all();
    for (int i = 0; i < 8; i++) begin
      read_csr(all_regs[i]);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      req.valid  <= 1'b0;
      trap.valid <= 1'b0;
      mret       <= 1'b0;
    end
  endtask

  task automatic raise_trap(input word_t cause, input word_t pc);
    @(posedge clk);
    req.valid <= 1'b0;
    trap      <= '{valid: 1'b1, cause: cause, pc: pc};
    @(posedge clk);
    trap.valid <= 1'b0;
  endtask

  task automatic return_from_trap();
    @(posedge clk);
    req.valid <= 1'b0;
    mret      <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
  endtask

  task automatic end_test(input string name, input int mark);
    $display("%s: %0d errors", name, errors - mark);
  endtask

  // compares the last cycle, then steps the model over the next edge
  always @(negedge clk) begin : model_and_check
    ref_result_t r;
    word_t       old_mstatus;
    word_t       old_mtvec;
    word_t       old_mepc;
    word_t       ms;
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        model[i] = '0;
      end
      model[IDX_MTVEC]   = MTVEC_RESET;
      model[IDX_MHARTID] = HART_ID;
      exp_resp_valid     = 1'b0;
      exp_redirect_valid = 1'b0;
    end else begin
      checks++;
      if (resp.valid !== exp_resp_valid) begin
        report_error($sformatf("resp.valid %b, expected %b", resp.valid, exp_resp_valid));
      end else if (exp_resp_valid && (resp.rdata !== exp_resp.rdata ||
                                      resp.illegal !== exp_resp.illegal)) begin
        report_error($sformatf("rdata %h illegal %b, expected %h %b", resp.rdata,
                               resp.illegal, exp_resp.rdata, exp_resp.illegal));
      end
      checks++;
      if (redirect_valid !== exp_redirect_valid) begin
        report_error($sformatf("redirect_valid %b, expected %b", redirect_valid,
                               exp_redirect_valid));
      end else if (exp_redirect_valid && redirect_pc !== exp_redirect_pc) begin
        report_error($sformatf("redirect_pc %h, expected %h", redirect_pc, exp_redirect_pc));
      end
      old_mstatus    = model[IDX_MSTATUS];
      old_mtvec      = model[IDX_MTVEC];
      old_mepc       = model[IDX_MEPC];
      exp_resp_valid = req.valid;
      if (req.valid) begin
        r        = ref_csr(req.addr, req.op, req.zimm, req.rs1_data);
        exp_resp = r;
        if (!r.illegal) begin
          model[reg_index(req.addr)] = r.next;
        end
      end
      // counter steps on top of any software write
      model[IDX_MCYCLE]  = model[IDX_MCYCLE] + 32'd1;
      exp_redirect_valid = trap.valid || mret;
      ms                 = old_mstatus;
      if (trap.valid) begin
        ms[MSTATUS_MPIE]   = old_mstatus[MSTATUS_MIE];
        ms[MSTATUS_MIE]    = 1'b0;
        model[IDX_MEPC]    = trap.pc;
        model[IDX_MCAUSE]  = trap.cause;
        model[IDX_MSTATUS] = ms;
        exp_redirect_pc    = {old_mtvec[31:2], 2'b00};
      end else if (mret) begin
        ms[MSTATUS_MIE]    = old_mstatus[MSTATUS_MPIE];
        ms[MSTATUS_MPIE]   = 1'b1;
        model[IDX_MSTATUS] = ms;
        exp_redirect_pc    = old_mepc;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin : stimulus
    int        mark;
    csr_addr_t addr;
    csr_addr_t rand_regs [4];
    clk          = 1'b0;
    reset        = 1'b1;
    req          = '0;
    trap         = '0;
    mret         = 1'b0;
    seed         = 80;
    checks       = 0;
    errors       = 0;
    cycle_count  = 0;
    exp_resp     = '0;
    all_regs     = '{ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH,
                     ADDR_MEPC, ADDR_MCAUSE, ADDR_MCYCLE, ADDR_MHARTID};
    rand_regs    = '{ADDR_MSCRATCH, ADDR_MIE, ADDR_MTVEC, ADDR_MEPC};
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    mark = errors;
    read_all();
    idle(2);
    end_test("test 1 reset values", mark);

    mark = errors;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      issue(rand_regs[rand_below(4)], pick_op(rand_below(6)), zimm_t'($random(seed)),
            word_t'($random(seed)));
    end
    for (int i = 0; i < 4; i++) begin
      read_csr(rand_regs[i]);
    end
    idle(2);
    end_test("test 2 random operations", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      issue(all_regs[i], CSRRS, 5'd0, word_t'($random(seed)));
      issue(all_regs[i], CSRRC, 5'd0, word_t'($random(seed)));
      issue(all_regs[i], CSRRSI, 5'd0, word_t'($random(seed)));
      issue(all_regs[i], CSRRCI, 5'd0, word_t'($random(seed)));
    end
    read_all();
    idle(2);
    end_test("test 3 zero source set and clear", mark);

    mark = errors;
    issue(12'h301, CSRRW, 5'd1, word_t'($random(seed)));
    issue(12'h7C0, CSRRSI, 5'd9, '0);
    for (int i = 0; i < 6; i++) begin
      do begin
        addr = csr_addr_t'($random(seed));
      end while (reg_index(addr) >= 0);
      issue(addr, pick_op(rand_below(6)), zimm_t'($random(seed)), word_t'($random(seed)));
    end
    issue(ADDR_MHARTID, CSRRW, 5'd0, 32'hFFFF_FFFF);
    issue(ADDR_MHARTID, CSRRWI, 5'd3, '0);
    issue(ADDR_MHARTID, CSRRSI, 5'd1, '0);
    issue(ADDR_MHARTID, CSRRC, 5'd7, 32'hFFFF_FFFF);
    read_all();
    idle(2);
    end_test("test 4 illegal requests", mark);

    mark = errors;
    // MIE set, mtvec with nonzero low bits
    issue(ADDR_MSTATUS, CSRRWI, 5'd8, '0);
    issue(ADDR_MTVEC, CSRRW, 5'd1, 32'h0000_0203);
    raise_trap(32'h0000_000B, 32'h8000_0040);
    read_csr(ADDR_MEPC);
    read_csr(ADDR_MCAUSE);
    read_csr(ADDR_MSTATUS);
    return_from_trap();
    read_csr(ADDR_MSTATUS);
    idle(2);
    end_test("test 5 trap and mret", mark);

    mark = errors;
    read_csr(ADDR_MCYCLE);
    idle(5);
    read_csr(ADDR_MCYCLE);
    issue(ADDR_MCYCLE, CSRRW, 5'd1, 32'h0000_1000);
    idle(3);
    read_csr(ADDR_MCYCLE);
    issue(ADDR_MCYCLE, CSRRCI, 5'd15, '0);
    read_csr(ADDR_MCYCLE);
    idle(2);
    end_test("test 6 mcycle", mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/csr_pkg.sv
logic/csr_reg.sv
logic/csr_counter.sv
logic/csr_file.sv
logic/csr_trap_ctrl.sv
logic/csr_unit.sv
verif/csr_unit_asserts.sv
verif/csr_unit_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module csr_unit_tb -f filelist.f -o csr_unit_sim
	./obj_dir/csr_unit_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test OK" $(LOG)
	! grep -q "Test FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
